/* hw/chdr_ep_params.svh */
// CHDR endpoint parameters

`ifndef CHDR_EP_PARAMS_SVH
`define CHDR_EP_PARAMS_SVH

// Bus width
`define CHDR_W 64

// ----------------------------------------
// Register map
// ----------------------------------------
`define REG_EPID_SELF              16'h00
`define REG_OSTRM_CTRL_STATUS      16'h04
`define REG_OSTRM_DST_EPID         16'h08
`define REG_OSTRM_FC_FREQ_BYTES_LO 16'h0C
`define REG_OSTRM_FC_FREQ_BYTES_HI 16'h10
`define REG_OSTRM_FC_FREQ_PKTS     16'h14
`define REG_OSTRM_FC_HEADROOM      16'h18
`define REG_CNT_CTRL               16'h2C
`define REG_CNT_DATA               16'h30
`define REG_CNT_STRS               16'h34
`define REG_CNT_DROP               16'h38

// Per-lane packet counters
`define PKT_CNT_W 32

`endif

/* hw/chdr_ep_pkg.sv */
// CHDR endpoint types

`include "chdr_ep_params.svh"

package chdr_ep_pkg;

  // CHDR packet types, as coded in the header
  typedef enum logic [2:0] {
    PKT_MGMT    = 3'd0,
    PKT_STRS    = 3'd1,
    PKT_STRC    = 3'd2,
    PKT_CTRL    = 3'd4,
    PKT_DATA    = 3'd6,
    PKT_DATA_TS = 3'd7
  } chdr_pkt_type_e;

  // First word of every packet
  typedef struct packed {
    logic [5:0]     vc;
    logic           eob;
    logic           eov;
    chdr_pkt_type_e pkt_type;
    logic [4:0]     num_mdata;
    logic [15:0]    seq_num;
    logic [15:0]    length;
    logic [15:0]    dst_epid;
  } chdr_header_t;

  // One bus beat
  typedef struct packed {
    logic               tlast;
    logic [`CHDR_W-1:0] tdata;
  } chdr_beat_t;

  // Destination lane of a classified packet
  typedef enum logic [1:0] {
    LANE_STRS = 2'd0,
    LANE_DATA = 2'd1,
    LANE_CTRL = 2'd2,
    LANE_DROP = 2'd3
  } chdr_lane_e;

  // ----------------------------------------
  // Control port
  // ----------------------------------------
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [15:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] data;
  } ctrlport_resp_t;

  // Outgoing stream configuration
  typedef struct packed {
    logic [15:0] epid_self;
    logic [15:0] dst_epid;
    logic        cfg_start;
    logic        lossy_xport;
    logic [39:0] fc_freq_bytes;
    logic [23:0] fc_freq_pkts;
    logic [15:0] headroom_bytes;
    logic [7:0]  headroom_pkts;
    logic [1:0]  spare;
  } ostrm_cfg_t;

  // One bit per lane, LSB is the stream-status lane
  typedef struct packed {
    logic drop;
    logic ctrl;
    logic data;
    logic strs;
  } lane_hit_t;

endpackage

/* hw/chdr_pkt_classifier.sv */
// CHDR packet classifier

`timescale 1ns/1ps

module chdr_pkt_classifier
  import chdr_ep_pkg::*;
(
  input  logic       rfnoc_chdr_clk,
  input  logic       rfnoc_chdr_rst,
  // Incoming CHDR
  input  chdr_beat_t i_chdr,
  input  logic       i_chdr_valid,
  output logic       o_chdr_ready,
  // Lane outputs
  output chdr_beat_t o_ctrl,
  output chdr_beat_t o_data,
  output chdr_beat_t o_strs,
  output logic       o_ctrl_valid,
  output logic       o_data_valid,
  output logic       o_strs_valid,
  input  logic       i_ctrl_ready,
  input  logic       i_data_ready,
  input  logic       i_strs_ready,
  // Header counting
  output lane_hit_t  o_lane_hit
);

  function automatic chdr_lane_e lane_of(input chdr_pkt_type_e pkt_type);
    case (pkt_type)
      PKT_CTRL:                       lane_of = LANE_CTRL;
      PKT_STRC, PKT_DATA, PKT_DATA_TS: lane_of = LANE_DATA;
      PKT_STRS:                       lane_of = LANE_STRS;
      // MGMT and reserved codes
      default:                        lane_of = LANE_DROP;
    endcase
  endfunction

  chdr_header_t hdr;
  chdr_lane_e   sel_lane;
  chdr_lane_e   lane_q;
  logic         sop_q;
  logic         accept;

  // Lane registers, indexed by chdr_lane_e
  chdr_beat_t   lane_beat [3];
  logic [2:0]   lane_vld;
  logic [2:0]   lane_rdy;
  logic [2:0]   lane_free;
  logic [3:0]   lane_free_all;

  // ----------------------------------------
  // Lane selection
  // ----------------------------------------
  assign hdr      = chdr_header_t'(i_chdr.tdata);
  assign sel_lane = sop_q ? lane_of(hdr.pkt_type) : lane_q;

  assign lane_rdy      = {i_ctrl_ready, i_data_ready, i_strs_ready};
  assign lane_free     = ~lane_vld | lane_rdy;
  // Drop sink never stalls
  assign lane_free_all = {1'b1, lane_free};

  assign o_chdr_ready = lane_free_all[sel_lane];
  assign accept       = i_chdr_valid && o_chdr_ready;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      sop_q  <= 1'b1;
      lane_q <= LANE_DROP;
    end else if (accept) begin
      sop_q <= i_chdr.tlast;
      if (sop_q) begin
        lane_q <= sel_lane;
      end
    end
  end

  assign o_lane_hit = (accept && sop_q) ? lane_hit_t'(4'b0001 << sel_lane) : '0;

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  for (genvar i = 0; i < 3; i++) begin : g_lane
    always_ff @(posedge rfnoc_chdr_clk) begin
      if (rfnoc_chdr_rst) begin
        lane_vld[i] <= 1'b0;
      end else if (accept && sel_lane == chdr_lane_e'(i)) begin
        lane_vld[i] <= 1'b1;
      end else if (lane_rdy[i]) begin
        lane_vld[i] <= 1'b0;
      end
    end

    always_ff @(posedge rfnoc_chdr_clk) begin
      if (accept && sel_lane == chdr_lane_e'(i)) begin
        lane_beat[i] <= i_chdr;
      end
    end
  end

  assign o_strs       = lane_beat[LANE_STRS];
  assign o_data       = lane_beat[LANE_DATA];
  assign o_ctrl       = lane_beat[LANE_CTRL];
  assign o_strs_valid = lane_vld[LANE_STRS];
  assign o_data_valid = lane_vld[LANE_DATA];
  assign o_ctrl_valid = lane_vld[LANE_CTRL];

endmodule

/* hw/ep_reg_file.sv */
// Endpoint register file

`timescale 1ns/1ps

`include "chdr_ep_params.svh"

module ep_reg_file
  import chdr_ep_pkg::*;
(
  input  logic           rfnoc_chdr_clk,
  input  logic           rfnoc_chdr_rst,
  // Control port
  input  ctrlport_req_t  i_ctrlport_req,
  output ctrlport_resp_t o_ctrlport_resp,
  // Classified packet pulses
  input  lane_hit_t      i_lane_hit,
  // Outgoing stream configuration
  output ostrm_cfg_t     o_ostrm_cfg
);

  ostrm_cfg_t           cfg_q;
  ctrlport_resp_t       resp_q;
  logic [3:0]           hit_vec;
  logic [`PKT_CNT_W-1:0] cnt_q [4];

  // ----------------------------------------
  // Register writes
  // ----------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      cfg_q <= '0;
    end else begin
      // Start strobe lasts a single cycle
      cfg_q.cfg_start <= 1'b0;
      if (i_ctrlport_req.wr) begin
        case (i_ctrlport_req.addr)
          `REG_EPID_SELF: begin
            cfg_q.epid_self <= i_ctrlport_req.data[15:0];
          end
          `REG_OSTRM_CTRL_STATUS: begin
            cfg_q.cfg_start   <= i_ctrlport_req.data[0];
            cfg_q.lossy_xport <= i_ctrlport_req.data[1];
          end
          `REG_OSTRM_DST_EPID: begin
            cfg_q.dst_epid <= i_ctrlport_req.data[15:0];
          end
          `REG_OSTRM_FC_FREQ_BYTES_LO: begin
            cfg_q.fc_freq_bytes[31:0] <= i_ctrlport_req.data;
          end
          `REG_OSTRM_FC_FREQ_BYTES_HI: begin
            cfg_q.fc_freq_bytes[39:32] <= i_ctrlport_req.data[7:0];
          end
          `REG_OSTRM_FC_FREQ_PKTS: begin
            cfg_q.fc_freq_pkts <= i_ctrlport_req.data[23:0];
          end
          `REG_OSTRM_FC_HEADROOM: begin
            cfg_q.headroom_bytes <= i_ctrlport_req.data[15:0];
            cfg_q.headroom_pkts  <= i_ctrlport_req.data[23:16];
          end
          default: begin
          end
        endcase
      end
    end
  end

  assign o_ostrm_cfg = cfg_q;

  // ----------------------------------------
  // Lane packet counters
  // ----------------------------------------
  assign hit_vec = i_lane_hit;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      for (int i = 0; i < 4; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        // Wraps at full scale
        if (hit_vec[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------
  // Read data and ack
  // ----------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      resp_q <= '0;
    end else begin
      resp_q.ack <= i_ctrlport_req.wr | i_ctrlport_req.rd;
      if (i_ctrlport_req.rd) begin
        case (i_ctrlport_req.addr)
          `REG_EPID_SELF:         resp_q.data <= {16'h0, cfg_q.epid_self};
          `REG_OSTRM_CTRL_STATUS: resp_q.data <= {30'h0, cfg_q.lossy_xport, 1'b0};
          `REG_CNT_CTRL:          resp_q.data <= cnt_q[LANE_CTRL];
          `REG_CNT_DATA:          resp_q.data <= cnt_q[LANE_DATA];
          `REG_CNT_STRS:          resp_q.data <= cnt_q[LANE_STRS];
          `REG_CNT_DROP:          resp_q.data <= cnt_q[LANE_DROP];
          // Write-only and unmapped addresses
          default:                resp_q.data <= 32'h0;
        endcase
      end
    end
  end

  assign o_ctrlport_resp = resp_q;

endmodule

/* hw/chdr_out_arbiter.sv */
// CHDR return-lane arbiter

`timescale 1ns/1ps

module chdr_out_arbiter
  import chdr_ep_pkg::*;
(
  input  logic       rfnoc_chdr_clk,
  input  logic       rfnoc_chdr_rst,
  // Return lanes
  input  chdr_beat_t i_ctrl_ret,
  input  logic       i_ctrl_ret_valid,
  output logic       o_ctrl_ret_ready,
  input  chdr_beat_t i_strs_ret,
  input  logic       i_strs_ret_valid,
  output logic       o_strs_ret_ready,
  input  chdr_beat_t i_data_ret,
  input  logic       i_data_ret_valid,
  output logic       o_data_ret_ready,
  // Outgoing CHDR
  output chdr_beat_t o_chdr_out,
  output logic       o_chdr_out_valid,
  input  logic       i_chdr_out_ready
);

  // Inputs in priority order, 0 is highest
  chdr_beat_t beat_in [3];
  logic [2:0] in_vld;
  logic [2:0] in_rdy;

  logic [1:0] grant_q;
  logic       in_pkt_q;
  logic [1:0] pri_pick;
  logic [1:0] sel;
  logic       out_free;
  logic       take;

  chdr_beat_t out_beat_q;
  logic       out_vld_q;

  assign beat_in[0] = i_ctrl_ret;
  assign beat_in[1] = i_strs_ret;
  assign beat_in[2] = i_data_ret;
  assign in_vld     = {i_data_ret_valid, i_strs_ret_valid, i_ctrl_ret_valid};

  // ----------------------------------------
  // Grant selection
  // ----------------------------------------
  always_comb begin
    if (in_vld[0]) begin
      pri_pick = 2'd0;
    end else if (in_vld[1]) begin
      pri_pick = 2'd1;
    end else begin
      pri_pick = 2'd2;
    end
  end

  // Priority only applies between packets
  assign sel      = in_pkt_q ? grant_q : pri_pick;
  assign out_free = !out_vld_q || i_chdr_out_ready;
  assign take     = in_vld[sel] && out_free;

  for (genvar i = 0; i < 3; i++) begin : g_rdy
    assign in_rdy[i] = out_free && (sel == 2'(i));
  end

  assign o_ctrl_ret_ready = in_rdy[0];
  assign o_strs_ret_ready = in_rdy[1];
  assign o_data_ret_ready = in_rdy[2];

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      grant_q  <= 2'd0;
      in_pkt_q <= 1'b0;
    end else if (take) begin
      grant_q  <= sel;
      in_pkt_q <= !beat_in[sel].tlast;
    end
  end

  // ----------------------------------------
  // Output register
  // ----------------------------------------
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      out_vld_q <= 1'b0;
    end else if (take) begin
      out_vld_q <= 1'b1;
    end else if (i_chdr_out_ready) begin
      out_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (take) begin
      out_beat_q <= beat_in[sel];
    end
  end

  assign o_chdr_out       = out_beat_q;
  assign o_chdr_out_valid = out_vld_q;

endmodule

/* hw/chdr_stream_ep.sv */
// CHDR stream endpoint top level

`timescale 1ns/1ps

module chdr_stream_ep
  import chdr_ep_pkg::*;
(
  input  logic           rfnoc_chdr_clk,
  input  logic           rfnoc_chdr_rst,
  // Incoming CHDR
  input  chdr_beat_t     i_chdr,
  input  logic           i_chdr_valid,
  output logic           o_chdr_ready,
  // Classified lanes
  output chdr_beat_t     o_ctrl,
  output logic           o_ctrl_valid,
  input  logic           i_ctrl_ready,
  output chdr_beat_t     o_data,
  output logic           o_data_valid,
  input  logic           i_data_ready,
  output chdr_beat_t     o_strs,
  output logic           o_strs_valid,
  input  logic           i_strs_ready,
  // Return lanes
  input  chdr_beat_t     i_ctrl_ret,
  input  logic           i_ctrl_ret_valid,
  output logic           o_ctrl_ret_ready,
  input  chdr_beat_t     i_strs_ret,
  input  logic           i_strs_ret_valid,
  output logic           o_strs_ret_ready,
  input  chdr_beat_t     i_data_ret,
  input  logic           i_data_ret_valid,
  output logic           o_data_ret_ready,
  // Outgoing CHDR
  output chdr_beat_t     o_chdr_out,
  output logic           o_chdr_out_valid,
  input  logic           i_chdr_out_ready,
  // Control port and configuration
  input  ctrlport_req_t  i_ctrlport_req,
  output ctrlport_resp_t o_ctrlport_resp,
  output ostrm_cfg_t     o_ostrm_cfg
);

  lane_hit_t lane_hit;

  // ----------------------------------------
  // Ingress
  // ----------------------------------------
  chdr_pkt_classifier u_classifier (
    .rfnoc_chdr_clk (rfnoc_chdr_clk),
    .rfnoc_chdr_rst (rfnoc_chdr_rst),
    .i_chdr         (i_chdr),
    .i_chdr_valid   (i_chdr_valid),
    .o_chdr_ready   (o_chdr_ready),
    .o_ctrl         (o_ctrl),
    .o_data         (o_data),
    .o_strs         (o_strs),
    .o_ctrl_valid   (o_ctrl_valid),
    .o_data_valid   (o_data_valid),
    .o_strs_valid   (o_strs_valid),
    .i_ctrl_ready   (i_ctrl_ready),
    .i_data_ready   (i_data_ready),
    .i_strs_ready   (i_strs_ready),
    .o_lane_hit     (lane_hit)
  );

  ep_reg_file u_reg_file (
    .rfnoc_chdr_clk  (rfnoc_chdr_clk),
    .rfnoc_chdr_rst  (rfnoc_chdr_rst),
    .i_ctrlport_req  (i_ctrlport_req),
    .o_ctrlport_resp (o_ctrlport_resp),
    .i_lane_hit      (lane_hit),
    .o_ostrm_cfg     (o_ostrm_cfg)
  );

  // ----------------------------------------
  // Egress
  // ----------------------------------------
  chdr_out_arbiter u_arbiter (
    .rfnoc_chdr_clk   (rfnoc_chdr_clk),
    .rfnoc_chdr_rst   (rfnoc_chdr_rst),
    .i_ctrl_ret       (i_ctrl_ret),
    .i_ctrl_ret_valid (i_ctrl_ret_valid),
    .o_ctrl_ret_ready (o_ctrl_ret_ready),
    .i_strs_ret       (i_strs_ret),
    .i_strs_ret_valid (i_strs_ret_valid),
    .o_strs_ret_ready (o_strs_ret_ready),
    .i_data_ret       (i_data_ret),
    .i_data_ret_valid (i_data_ret_valid),
    .o_data_ret_ready (o_data_ret_ready),
    .o_chdr_out       (o_chdr_out),
    .o_chdr_out_valid (o_chdr_out_valid),
    .i_chdr_out_ready (i_chdr_out_ready)
  );

endmodule

/* sim/tb_chdr_stream_ep.sv */
// CHDR stream endpoint testbench

`timescale 1ns/1ps

`include "chdr_ep_params.svh"

module tb_chdr_stream_ep
  import chdr_ep_pkg::*;
();

  typedef struct packed {
    logic [2:0]  ptype;
    logic [3:0]  nbeats;
    chdr_lane_e  lane;
    logic [31:0] seed;
  } stim_row_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
  } reg_row_t;

  localparam int OUT_Q = 3;

  // Types 3 and 5 are reserved
  stim_row_t stim_tbl [8] = '{
    {3'd4, 4'd3, LANE_CTRL, 32'd73},  {3'd6, 4'd4, LANE_DATA, 32'd146},
    {3'd1, 4'd2, LANE_STRS, 32'd219}, {3'd0, 4'd2, LANE_DROP, 32'd292},
    {3'd2, 4'd1, LANE_DATA, 32'd365}, {3'd3, 4'd2, LANE_DROP, 32'd438},
    {3'd7, 4'd3, LANE_DATA, 32'd511}, {3'd5, 4'd1, LANE_DROP, 32'd584}
  };

  // Read value after the write is masked or zero
  reg_row_t reg_tbl [8] = '{
    {`REG_EPID_SELF,              32'hABCD_1234, 32'h0000_1234},
    {`REG_OSTRM_DST_EPID,         32'h5555_BEEF, 32'h0},
    {`REG_OSTRM_FC_FREQ_BYTES_LO, 32'h89AB_CDEF, 32'h0},
    {`REG_OSTRM_FC_FREQ_BYTES_HI, 32'hFFFF_FF12, 32'h0},
    {`REG_OSTRM_FC_FREQ_PKTS,     32'hAA12_3456, 32'h0},
    {`REG_OSTRM_FC_HEADROOM,      32'hFFA5_1357, 32'h0},
    {`REG_OSTRM_CTRL_STATUS,      32'h0000_0003, 32'h0000_0002},
    {16'h0040,                    32'hDEAD_BEEF, 32'h0}
  };

  logic           rfnoc_chdr_clk;
  logic           rfnoc_chdr_rst;
  chdr_beat_t     in_beat;
  logic           in_valid;
  logic           o_chdr_ready;
  chdr_beat_t     o_ctrl, o_data, o_strs, o_chdr_out;
  logic           o_ctrl_valid, o_data_valid, o_strs_valid, o_chdr_out_valid;
  logic           ctrl_rdy, data_rdy, strs_rdy, out_rdy;
  chdr_beat_t     ret_beat [3];
  logic [2:0]     ret_vld;
  logic [2:0]     ret_rdy;
  ctrlport_req_t  req;
  ctrlport_resp_t resp;
  ostrm_cfg_t     cfg;

  chdr_beat_t  exp_q [4][$];
  string       lane_name [4] = '{"o_strs", "o_data", "o_ctrl", "o_chdr_out"};
  logic        stall_vld [4];
  chdr_beat_t  stall_beat [4];
  logic [31:0] rng = 32'd73;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;
  int          start_cycles = 0;

  chdr_stream_ep i_chdr_stream_ep (
    .rfnoc_chdr_clk   (rfnoc_chdr_clk),
    .rfnoc_chdr_rst   (rfnoc_chdr_rst),
    .i_chdr           (in_beat),
    .i_chdr_valid     (in_valid),
    .o_chdr_ready     (o_chdr_ready),
    .o_ctrl           (o_ctrl),
    .o_ctrl_valid     (o_ctrl_valid),
    .i_ctrl_ready     (ctrl_rdy),
    .o_data           (o_data),
    .o_data_valid     (o_data_valid),
    .i_data_ready     (data_rdy),
    .o_strs           (o_strs),
    .o_strs_valid     (o_strs_valid),
    .i_strs_ready     (strs_rdy),
    .i_ctrl_ret       (ret_beat[0]),
    .i_ctrl_ret_valid (ret_vld[0]),
    .o_ctrl_ret_ready (ret_rdy[0]),
    .i_strs_ret       (ret_beat[1]),
    .i_strs_ret_valid (ret_vld[1]),
    .o_strs_ret_ready (ret_rdy[1]),
    .i_data_ret       (ret_beat[2]),
    .i_data_ret_valid (ret_vld[2]),
    .o_data_ret_ready (ret_rdy[2]),
    .o_chdr_out       (o_chdr_out),
    .o_chdr_out_valid (o_chdr_out_valid),
    .i_chdr_out_ready (out_rdy),
    .i_ctrlport_req   (req),
    .o_ctrlport_resp  (resp),
    .o_ostrm_cfg      (cfg)
  );

  initial begin
    rfnoc_chdr_clk = 1'b0;
    forever #2 rfnoc_chdr_clk = ~rfnoc_chdr_clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Beat b of table row idx with the header first
  function automatic chdr_beat_t pkt_beat(input stim_row_t row, input int idx, input int b);
    chdr_beat_t  beat;
    logic [31:0] x;
    x = row.seed;
    beat.tlast = (b == row.nbeats - 1);
    if (b == 0) begin
      beat.tdata = {8'h00, row.ptype, 5'h0, 16'(idx), 16'(row.nbeats * 8), row.seed[15:0]};
    end else begin
      for (int i = 0; i < b; i++) begin
        x = next_random(x);
      end
      beat.tdata = {x, x ^ 32'(idx)};
    end
    return beat;
  endfunction

  task automatic compare_value(input string name, input logic [129:0] actual,
                               input logic [129:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("Error: time %0t, %s expected 0x%0h actual 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic queue_pkt(input int q, input int r);
    for (int b = 0; b < stim_tbl[r].nbeats; b++) begin
      exp_q[q].push_back(pkt_beat(stim_tbl[r], r, b));
    end
  endtask

  task automatic send_pkt(input int r);
    for (int b = 0; b < stim_tbl[r].nbeats; b++) begin
      in_beat  = pkt_beat(stim_tbl[r], r, b);
      in_valid = 1'b1;
      do @(posedge rfnoc_chdr_clk); while (!o_chdr_ready);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic send_ret(input int k, input int r);
    for (int b = 0; b < stim_tbl[r].nbeats; b++) begin
      ret_beat[k] = pkt_beat(stim_tbl[r], r, b);
      ret_vld[k]  = 1'b1;
      do @(posedge rfnoc_chdr_clk); while (!ret_rdy[k]);
      #1;
    end
    ret_vld[k] = 1'b0;
  endtask

  task automatic reg_access(input logic is_wr, input logic [15:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    req = '{wr: is_wr, rd: !is_wr, addr: addr, data: wdata};
    @(posedge rfnoc_chdr_clk);
    compare_value("o_ctrlport_resp.ack (early)", resp.ack, 1'b0);
    #1;
    req.wr = 1'b0;
    req.rd = 1'b0;
    @(posedge rfnoc_chdr_clk);
    compare_value("o_ctrlport_resp.ack", resp.ack, 1'b1);
    rdata = resp.data;
    #1;
  endtask

  // Pops the expected beat and checks that a stalled beat holds
  task automatic observe(input int idx, input chdr_beat_t beat, input logic vld,
                         input logic rdy);
    if (stall_vld[idx]) begin
      compare_value({lane_name[idx], "_valid (held)"}, vld, 1'b1);
      compare_value({lane_name[idx], " (held)"}, beat, stall_beat[idx]);
    end
    if (vld && rdy) begin
      if (exp_q[idx].size() == 0) begin
        errors++;
        $display("Unexpected beat on %s at time %0t", lane_name[idx], $time);
      end else begin
        compare_value(lane_name[idx], beat, exp_q[idx].pop_front());
      end
    end
    stall_vld[idx]  = vld && !rdy;
    stall_beat[idx] = beat;
  endtask

  // ----------------------------------------
  // Monitors, back-pressure and timeout
  // ----------------------------------------
  always @(posedge rfnoc_chdr_clk) begin
    if (rfnoc_chdr_rst) begin
      stall_vld = '{default: 1'b0};
    end else begin
      observe(LANE_STRS, o_strs, o_strs_valid, strs_rdy);
      observe(LANE_DATA, o_data, o_data_valid, data_rdy);
      observe(LANE_CTRL, o_ctrl, o_ctrl_valid, ctrl_rdy);
      observe(OUT_Q, o_chdr_out, o_chdr_out_valid, out_rdy);
      if (cfg.cfg_start) begin
        start_cycles++;
      end
    end
  end

  always @(posedge rfnoc_chdr_clk) begin
    #1;
    rng = next_random(rng);
    {ctrl_rdy, data_rdy, strs_rdy, out_rdy} = rng[3:0] | rng[7:4];
  end

  always @(posedge rfnoc_chdr_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] rd;
    ostrm_cfg_t  exp_cfg;
    int          cnt_exp [4];
    logic [15:0] cnt_addr [4];
    int          total_beats;

    rfnoc_chdr_rst = 1'b1;
    in_beat        = '0;
    in_valid       = 1'b0;
    {ctrl_rdy, data_rdy, strs_rdy, out_rdy} = 4'hF;
    ret_beat       = '{default: '0};
    ret_vld        = 3'b000;
    req            = '0;
    cnt_exp        = '{default: 0};
    cnt_addr       = '{`REG_CNT_STRS, `REG_CNT_DATA, `REG_CNT_CTRL, `REG_CNT_DROP};
    total_beats    = 0;
    foreach (stim_tbl[r]) begin
      total_beats += stim_tbl[r].nbeats;
      cnt_exp[stim_tbl[r].lane]++;
    end
    cycle_limit = 40 * total_beats + 500;
    repeat (5) @(posedge rfnoc_chdr_clk);
    #1;
    rfnoc_chdr_rst = 1'b0;
    compare_value("valids after reset", {o_ctrl_valid, o_data_valid, o_strs_valid,
                  o_chdr_out_valid, resp.ack}, 5'b0);
    compare_value("o_ostrm_cfg after reset", cfg, '0);

    // ----------------------------------------
    // Register writes and reads
    // ----------------------------------------
    foreach (reg_tbl[i]) begin
      reg_access(1'b1, reg_tbl[i].addr, reg_tbl[i].wdata, rd);
      reg_access(1'b0, reg_tbl[i].addr, 32'h0, rd);
      compare_value($sformatf("read data at 0x%02h", reg_tbl[i].addr), rd, reg_tbl[i].rdata);
    end
    exp_cfg = '{epid_self: 16'h1234, dst_epid: 16'hBEEF, cfg_start: 1'b0, lossy_xport: 1'b1,
                fc_freq_bytes: 40'h12_89AB_CDEF, fc_freq_pkts: 24'h12_3456,
                headroom_bytes: 16'h1357, headroom_pkts: 8'hA5, spare: 2'b00};
    compare_value("o_ostrm_cfg", cfg, exp_cfg);
    compare_value("cfg_start cycles", start_cycles, 1);

    // Routing and drop through the classifier
    foreach (stim_tbl[r]) begin
      if (stim_tbl[r].lane != LANE_DROP) begin
        queue_pkt(stim_tbl[r].lane, r);
      end
      send_pkt(r);
    end
    while (exp_q[0].size() + exp_q[1].size() + exp_q[2].size() != 0) begin
      @(posedge rfnoc_chdr_clk);
    end
    #1;
    for (int l = 0; l < 4; l++) begin
      reg_access(1'b0, cnt_addr[l], 32'h0, rd);
      compare_value($sformatf("read data at 0x%02h", cnt_addr[l]), rd, cnt_exp[l]);
    end

    // Return lanes all at once and then data ahead of the others
    queue_pkt(OUT_Q, 0);
    queue_pkt(OUT_Q, 2);
    queue_pkt(OUT_Q, 1);
    fork
      send_ret(0, 0);
      send_ret(1, 2);
      send_ret(2, 1);
    join
    queue_pkt(OUT_Q, 6);
    queue_pkt(OUT_Q, 0);
    queue_pkt(OUT_Q, 2);
    fork
      send_ret(2, 6);
      begin
        do @(posedge rfnoc_chdr_clk); while (!(ret_vld[2] && ret_rdy[2]));
        #1;
        fork
          send_ret(0, 0);
          send_ret(1, 2);
        join
      end
    join
    while (exp_q[OUT_Q].size() != 0) begin
      @(posedge rfnoc_chdr_clk);
    end
    repeat (4) @(posedge rfnoc_chdr_clk);

    $display("Run complete with %0d error(s)", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
hw/chdr_ep_pkg.sv
hw/chdr_pkt_classifier.sv
hw/ep_reg_file.sv
hw/chdr_out_arbiter.sv
hw/chdr_stream_ep.sv
sim/tb_chdr_stream_ep.sv
